// File: design/execPkg.sv
`default_nettype none

package execPkg;

   // Datapath sizes
   localparam int dataWidth   = 16;
   localparam int regCount    = 8;
   localparam int regIdxWidth = 3;  // log2 of regCount
   localparam int immWidth    = 8;  // Immediate field, zero-extended

   typedef logic [7:0]             opcodeT;
   typedef logic [dataWidth-1:0]   dataT;
   typedef logic [regIdxWidth-1:0] regIdxT;
   typedef logic [1:0]             aluClassT;
   typedef logic [3:0]             aluOpT;

   // Arithmetic opcodes, bit 5 marks the immediate form
   localparam opcodeT opAddReg = 8'b0000_1000;
   localparam opcodeT opAddImm = 8'b0010_1000;
   localparam opcodeT opSubReg = 8'b0000_0100;
   localparam opcodeT opSubImm = 8'b0010_0100;
   localparam opcodeT opMovImm = 8'b0011_1010;
   localparam opcodeT opMovReg = 8'b0001_1010;

   // Memory and branch opcodes
   localparam opcodeT opLdrPos = 8'b0101_1001;
   localparam opcodeT opLdrNeg = 8'b0101_0001;
   localparam opcodeT opStrNeg = 8'b0101_0000;
   localparam opcodeT opCbz    = 8'b1011_0100;

   localparam aluClassT classMem   = 2'b00;
   localparam aluClassT classCbz   = 2'b01;
   localparam aluClassT classArith = 2'b10;

   localparam aluOpT aluAdd    = 4'b0010;
   localparam aluOpT aluSub    = 4'b0110;
   localparam aluOpT aluMovImm = 4'b1011;
   localparam aluOpT aluMovReg = 4'b1100;
   localparam aluOpT aluZero   = 4'b1001;  // Kept clear of shift-left 0111

   typedef struct packed {
      opcodeT              opcode;
      regIdxT              rd;   // Destination, also store data and CBZ source
      regIdxT              rn;
      regIdxT              rm;
      logic [immWidth-1:0] imm;
   } instT;

   typedef struct packed {
      aluClassT aluClass;
      logic     regWrite;  // Result goes back to rd
      logic     useImm;    // Operand B from imm instead of rm
      logic     memRead;
      logic     memWrite;
      logic     isBranch;
   } ctrlT;

   typedef struct packed {
      dataT   result;
      dataT   memAddr;
      dataT   storeData;
      logic   memRead;
      logic   memWrite;
      logic   branchTaken;
      logic   regWrite;
      regIdxT rd;
   } outcomeT;

endpackage

`default_nettype wire

// File: design/mainDecoder.sv
`timescale 1ns/10ps
`default_nettype none

// Opcode to ALU class and datapath control bits
module mainDecoder
   import execPkg::*;
(
   input  opcodeT opcode,
   output ctrlT   ctrl
);

   always_comb begin
      ctrl = '0;  // All controls off unless decoded

      case (opcode)
         opLdrPos,
         opLdrNeg: begin
            ctrl.aluClass = classMem;
            ctrl.memRead  = 1'b1;
            ctrl.useImm   = 1'b1;  // Offset from imm
         end

         opStrNeg: begin
            ctrl.aluClass = classMem;
            ctrl.memWrite = 1'b1;
            ctrl.useImm   = 1'b1;
         end

         opCbz: begin
            ctrl.aluClass = classCbz;
            ctrl.isBranch = 1'b1;  // Tests rd, no writeback
         end

         // Everything else treated as arithmetic
         default: begin
            ctrl.aluClass = classArith;
            ctrl.regWrite = 1'b1;
            ctrl.useImm   = opcode[5];  // Immediate forms have bit 5 set
         end
      endcase
   end

endmodule

`default_nettype wire

// File: design/aluControl.sv
`timescale 1ns/10ps
`default_nettype none

// Second decode level, class plus opcode to ALU operation
module aluControl
   import execPkg::*;
(
   input  aluClassT aluClass,
   input  opcodeT   opcodeField,
   output aluOpT    aluOperation
);

   always_comb begin
      aluOperation = aluAdd;  // Safe default, no latch

      case (aluClass)
         classMem: begin
            case (opcodeField)
               opLdrPos: aluOperation = aluAdd;  // rn + offset
               opLdrNeg: aluOperation = aluSub;  // rn - offset
               opStrNeg: aluOperation = aluSub;
               default:  aluOperation = aluAdd;
            endcase
         end

         classCbz: aluOperation = aluZero;  // Pass rd through, zero flag

         classArith: begin
            case (opcodeField)
               opAddReg,
               opAddImm: aluOperation = aluAdd;
               opSubReg,
               opSubImm: aluOperation = aluSub;
               opMovImm: aluOperation = aluMovImm;
               opMovReg: aluOperation = aluMovReg;
               default:  aluOperation = aluAdd;  // Unknown arith opcode acts as ADD
            endcase
         end

         default: aluOperation = aluAdd;  // Unused class 11
      endcase
   end

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/10ps
`default_nettype none

// 16-bit ALU, add/sub/move and zero test
module alu
   import execPkg::*;
(
   input  dataT  a,
   input  dataT  b,
   input  aluOpT operation,
   output dataT  result,
   output logic  zero
);

   always_comb begin
      case (operation)
         aluAdd:    result = a + b;  // Wraps at 16 bits
         aluSub:    result = a - b;
         aluMovImm: result = b;      // b is the zero-extended imm here
         aluMovReg: result = b;      // b is rm here

         // CBZ only needs the flag, value just passes through
         aluZero:   result = a;

         default:   result = a + b;
      endcase
   end

   // Flag always on operand A
   assign zero = (a == '0);

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/10ps
`default_nettype none

// 8 x 16 register file, 3 async read ports, 1 sync write
module regFile
   import execPkg::*;
(
   input  logic   clk,
   input  logic   rstN,
   input  regIdxT rdAddrA,
   input  regIdxT rdAddrB,
   input  regIdxT rdAddrC,
   output dataT   rdDataA,
   output dataT   rdDataB,
   output dataT   rdDataC,
   input  logic   wrEn,
   input  regIdxT wrAddr,
   input  dataT   wrData
);

   dataT regs [regCount];

   // Whole file clears on reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rdDataA = regs[rdAddrA];  // rn
   assign rdDataB = regs[rdAddrB];  // rm
   assign rdDataC = regs[rdAddrC];  // rd, for store data and CBZ

endmodule

`default_nettype wire

// File: design/execCore.sv
`timescale 1ns/10ps
`default_nettype none

// Single-issue execute stage, one cycle from instValid to outValid
module execCore
   import execPkg::*;
(
   input  logic    clk,
   input  logic    rstN,
   input  logic    instValid,
   input  instT    inst,
   output logic    outValid,
   output outcomeT outcome
);

   ctrlT    ctrl;
   aluOpT   aluOp;
   dataT    rnData;
   dataT    rmData;
   dataT    rdData;
   dataT    opA;
   dataT    opB;
   dataT    aluResult;
   logic    aluZeroFlag;
   outcomeT nextOutcome;

   mainDecoder u_mainDecoder (
      .opcode (inst.opcode),
      .ctrl   (ctrl)
   );

   aluControl u_aluControl (
      .aluClass     (ctrl.aluClass),
      .opcodeField  (inst.opcode),
      .aluOperation (aluOp)
   );

   // Write port fed from the same values that get registered below
   regFile u_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (inst.rn),
      .rdAddrB (inst.rm),
      .rdAddrC (inst.rd),
      .rdDataA (rnData),
      .rdDataB (rmData),
      .rdDataC (rdData),
      .wrEn    (nextOutcome.regWrite),
      .wrAddr  (nextOutcome.rd),
      .wrData  (nextOutcome.result)
   );

   assign opA = ctrl.isBranch ? rdData : rnData;  // CBZ tests rd
   assign opB = ctrl.useImm ? {{(dataWidth-immWidth){1'b0}}, inst.imm} : rmData;

   alu u_alu (
      .a         (opA),
      .b         (opB),
      .operation (aluOp),
      .result    (aluResult),
      .zero      (aluZeroFlag)
   );

   // Next outcome, flags only count with a valid instruction
   always_comb begin
      nextOutcome.result      = aluResult;
      nextOutcome.memAddr     = aluResult;  // rn +/- imm for loads and stores
      nextOutcome.storeData   = rdData;
      nextOutcome.memRead     = instValid & ctrl.memRead;
      nextOutcome.memWrite    = instValid & ctrl.memWrite;
      nextOutcome.branchTaken = instValid & ctrl.isBranch & aluZeroFlag;
      nextOutcome.regWrite    = instValid & ctrl.regWrite;
      nextOutcome.rd          = inst.rd;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         outValid <= 1'b0;
         outcome  <= '0;
      end else begin
         outValid <= instValid;  // Single pulse per instruction
         outcome  <= nextOutcome;
      end
   end

endmodule

`default_nettype wire

// File: verif/execCoreAssertions.sv
`timescale 1ns/10ps
`default_nettype none

// Protocol checks on the execute stage outputs
module execCoreAssertions
   import execPkg::*;
(
   input logic    clk,
   input logic    rstN,
   input logic    instValid,
   input logic    outValid,
   input outcomeT outcome
);

   // Exactly one cycle of latency
   validFollows: assert property (@(posedge clk) disable iff (!rstN)
      instValid |=> outValid)
      else $error("outValid missing one cycle after instValid");

   noSpuriousValid: assert property (@(posedge clk) disable iff (!rstN)
      !instValid |=> !outValid)
      else $error("outValid without a preceding instValid");

   // A load and a store never at once
   memExclusive: assert property (@(posedge clk) disable iff (!rstN)
      !(outcome.memRead && outcome.memWrite))
      else $error("memRead and memWrite both high");

   flagsNeedValid: assert property (@(posedge clk) disable iff (!rstN)
      !outValid |-> !(outcome.memRead || outcome.memWrite ||
                      outcome.branchTaken || outcome.regWrite))
      else $error("outcome flag set while outValid is low");

endmodule

bind execCore execCoreAssertions i_execCoreAssertions (
   .clk       (clk),
   .rstN      (rstN),
   .instValid (instValid),
   .outValid  (outValid),
   .outcome   (outcome)
);

`default_nettype wire

// File: verif/execCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

// Random instruction testbench for the execute stage with a register model
module execCoreTb
   import execPkg::*;
();

   localparam int numRandom = 1150;             // Random steps after directed ones
   localparam int numSteps  = 1200;             // Upper bound on all stimulus cycles
   localparam int maxCycles = numSteps + 100;   // Hang limit with margin

   logic    clk;
   logic    rstN;
   logic    instValid;
   instT    inst;
   logic    outValid;
   outcomeT outcome;

   integer  seed = 32'hf248ba13;
   int      cycleCount = 0;
   logic    prevValid = 1'b0;   // instValid as driven one cycle back
   dataT    modelRegs [regCount];
   outcomeT expQ [$];           // Predicted outcomes in issue order
   opcodeT  opList [10] = '{opAddReg, opAddImm, opSubReg, opSubImm, opMovImm,
                            opMovReg, opLdrPos, opLdrNeg, opStrNeg, opCbz};

   execCore i_execCore (
      .clk       (clk),
      .rstN      (rstN),
      .instValid (instValid),
      .inst      (inst),
      .outValid  (outValid),
      .outcome   (outcome)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   // Hang guard
   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= maxCycles) begin
         $display("Timeout: the run did not finish within the cycle limit");
         $display("tests failed");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic checkEq(input logic [15:0] actual, input logic [15:0] expected,
                          input string msg);
      if (actual !== expected) begin
         $display("[FAIL] %0t %s: got %h, expected %h", $time, msg, actual, expected);
         $display("tests failed");
         $fatal(1, "first mismatch");
      end
   endtask

   // Expected outcome from the ISA rules and the model registers
   function automatic outcomeT predictOutcome(instT in);
      outcomeT o;
      dataT    a;
      dataT    b;
      o = '0;
      a = modelRegs[in.rn];
      b = in.opcode[5] ? dataT'(in.imm) : modelRegs[in.rm];  // Arith operand B
      o.rd        = in.rd;
      o.storeData = modelRegs[in.rd];
      case (in.opcode)
         opLdrPos: begin
            o.memRead = 1'b1;
            o.memAddr = a + dataT'(in.imm);
         end
         opLdrNeg: begin
            o.memRead = 1'b1;
            o.memAddr = a - dataT'(in.imm);
         end
         opStrNeg: begin
            o.memWrite = 1'b1;
            o.memAddr  = a - dataT'(in.imm);
         end
         opCbz: o.branchTaken = (modelRegs[in.rd] == '0);
         default: begin
            o.regWrite = 1'b1;
            case (in.opcode)
               opSubReg, opSubImm: o.result = a - b;
               opMovImm, opMovReg: o.result = b;
               default:            o.result = a + b;  // ADD and unknown arith
            endcase
         end
      endcase
      return o;
   endfunction

   // Outcome of the instruction driven one falling edge earlier
   task automatic compareOutcome();
      outcomeT exp;
      checkEq(16'(outValid), 16'(prevValid), "outValid one cycle after instValid");
      if (prevValid) begin
         exp = expQ.pop_front();
         checkEq(16'(outcome.memRead), 16'(exp.memRead), "memRead");
         checkEq(16'(outcome.memWrite), 16'(exp.memWrite), "memWrite");
         checkEq(16'(outcome.branchTaken), 16'(exp.branchTaken), "branchTaken");
         checkEq(16'(outcome.regWrite), 16'(exp.regWrite), "regWrite");
         if (exp.regWrite) begin
            checkEq(outcome.result, exp.result, "result");
            checkEq(16'(outcome.rd), 16'(exp.rd), "rd");
         end
         if (exp.memRead || exp.memWrite)
            checkEq(outcome.memAddr, exp.memAddr, "memAddr");
         if (exp.memWrite)
            checkEq(outcome.storeData, exp.storeData, "storeData");
      end else begin
         // No flags when idle or in reset
         checkEq(16'({outcome.memRead, outcome.memWrite, outcome.branchTaken,
                      outcome.regWrite}), 16'h0, "flags while idle");
      end
   endtask

   // Check the last outcome and drive one instruction on the falling edge
   task automatic applyInst(input logic valid, input instT in);
      outcomeT exp;
      @(negedge clk);
      compareOutcome();
      instValid = valid;
      inst      = in;
      prevValid = valid;
      if (valid) begin
         exp = predictOutcome(in);
         expQ.push_back(exp);
         if (exp.regWrite)
            modelRegs[in.rd] = exp.result;  // Visible to the next instruction
      end
   endtask

   function automatic instT makeInst(opcodeT op, int rd, int rn, int rm, int imm);
      instT i;
      i.opcode = op;
      i.rd     = regIdxT'(rd);
      i.rn     = regIdxT'(rn);
      i.rm     = regIdxT'(rm);
      i.imm    = imm[7:0];
      return i;
   endfunction

   initial begin
      logic [31:0] r;
      logic [31:0] pick;
      instT        rndInst;
      rstN      = 1'b0;
      instValid = 1'b0;
      inst      = '0;
      for (int i = 0; i < regCount; i++)
         modelRegs[i] = '0;

      repeat (2) begin
         @(negedge clk);
         compareOutcome();  // Outputs low during reset
      end
      rstN = 1'b1;

      // Every register reads zero after reset
      for (int i = 0; i < regCount; i++)
         applyInst(1'b1, makeInst(opCbz, i, 0, 0, 0));

      // Dependent chain issued back to back
      applyInst(1'b1, makeInst(opMovImm, 1, 0, 0, 8'hf0));
      applyInst(1'b1, makeInst(opAddReg, 2, 1, 1, 0));
      applyInst(1'b1, makeInst(opSubImm, 3, 2, 0, 8'hff));
      applyInst(1'b1, makeInst(opStrNeg, 3, 2, 0, 8'h10));
      applyInst(1'b1, makeInst(opSubReg, 4, 3, 3, 0));   // r4 goes to zero
      applyInst(1'b1, makeInst(opCbz, 4, 0, 0, 0));
      repeat (3) applyInst(1'b0, makeInst(opAddImm, 5, 5, 5, 8'h55));

      for (int n = 0; n < numRandom; n++) begin
         r    = $random(seed);
         pick = $random(seed);
         rndInst.opcode = (pick[3:0] < 4'd10) ? opList[pick[3:0]] : pick[15:8];
         rndInst.rd     = r[2:0];
         rndInst.rn     = r[5:3];
         rndInst.rm     = r[8:6];
         rndInst.imm    = r[23:16];
         applyInst(r[31:30] != 2'b00, rndInst);  // About 3 in 4 valid
      end

      applyInst(1'b0, '0);  // Collect the last outcome
      @(negedge clk);
      compareOutcome();

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
design/execPkg.sv
design/mainDecoder.sv
design/aluControl.sv
design/alu.sv
design/regFile.sv
design/execCore.sv
verif/execCoreAssertions.sv
verif/execCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module execCoreTb -f files.f

out=$(./obj_dir/VexecCoreTb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "all tests passed"; then
   exit 0
else
   exit 1
fi
